// ==== src/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Register and data width
`define XLEN 64

// Integer registers, x0 included
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

// Fixed machine trap handler entry
`define TRAP_VECTOR 64'h0000_0000_0000_0200

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== src/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;    // One register or data value
    typedef logic [31:0]      instr_t;
    typedef logic [4:0]       reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,                          // Signed compare
        ALU_SLL,
        ALU_PASS_B                        // Operand B straight through
    } alu_op_e;

    // Same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_DOUBLE
    } mem_size_e;

    typedef enum logic [1:0] {
        OPA_REG,
        OPA_PC,
        OPA_ZERO
    } op_a_sel_e;

    typedef enum logic {
        OPB_REG,
        OPB_IMM
    } op_b_sel_e;

    typedef struct packed {
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        logic      writes_rd;
        logic      load;
        logic      store;
        mem_size_e mem_size;
        logic      load_unsigned;          // lbu, lhu, lwu
        logic      branch;                 // beq only
        logic      jal;
        logic      jalr;
        logic      mret;
    } decoded_t;

    // Wishbone classic master side
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        word_t                adr;         // Byte address
        word_t                dat;
        logic [`XLEN/8-1:0]   sel;         // One bit per byte lane
    } wb_req_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_rsp_t;

    typedef struct packed {
        logic     en;
        reg_idx_t addr;
        word_t    data;
    } rf_write_t;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode (
    input  rv_pkg::instr_t   instr_i,
    output rv_pkg::decoded_t dec_o
);
    import rv_pkg::*;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam instr_t     MRET      = 32'h3020_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j, shamt;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Sign extension through the signed cast
    assign imm_i = word_t'($signed(instr_i[31:20]));
    assign imm_s = word_t'($signed({instr_i[31:25], instr_i[11:7]}));
    assign imm_b = word_t'($signed({instr_i[31], instr_i[7], instr_i[30:25],
                                    instr_i[11:8], 1'b0}));
    assign imm_u = word_t'($signed({instr_i[31:12], 12'b0}));
    assign imm_j = word_t'($signed({instr_i[31], instr_i[19:12], instr_i[20],
                                    instr_i[30:21], 1'b0}));
    assign shamt = word_t'(instr_i[25:20]);                 // RV64 uses 6 bits

    always_comb begin
        dec_o               = '0;                          // Unknown means no effect
        dec_o.rd            = instr_i[11:7];
        dec_o.rs1           = instr_i[19:15];
        dec_o.rs2           = instr_i[24:20];
        dec_o.alu_op        = ALU_PASS_B;
        dec_o.op_a_sel      = OPA_ZERO;
        dec_o.op_b_sel      = OPB_IMM;
        dec_o.mem_size      = mem_size_e'(funct3[1:0]);
        dec_o.load_unsigned = funct3[2];
        case (opcode)
            OP_LUI: begin
                dec_o.imm       = imm_u;
                dec_o.writes_rd = 1'b1;                    // PASS_B of the U immediate
            end
            OP_AUIPC: begin
                dec_o.imm       = imm_u;
                dec_o.alu_op    = ALU_ADD;
                dec_o.op_a_sel  = OPA_PC;
                dec_o.writes_rd = 1'b1;
            end
            OP_IMM: begin
                dec_o.op_a_sel = OPA_REG;
                if (funct3 == 3'b000) begin                // addi
                    dec_o.imm       = imm_i;
                    dec_o.alu_op    = ALU_ADD;
                    dec_o.writes_rd = 1'b1;
                end else if (funct3 == 3'b001 && funct7[6:1] == 6'b0) begin  // slli
                    dec_o.imm       = shamt;
                    dec_o.alu_op    = ALU_SLL;
                    dec_o.writes_rd = 1'b1;
                end
            end
            OP_REG: begin
                dec_o.op_a_sel = OPA_REG;
                dec_o.op_b_sel = OPB_REG;
                if (funct7 == 7'b0000000 && funct3 == 3'b000) begin
                    dec_o.alu_op    = ALU_ADD;
                    dec_o.writes_rd = 1'b1;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_o.alu_op    = ALU_SUB;
                    dec_o.writes_rd = 1'b1;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b010) begin
                    dec_o.alu_op    = ALU_SLT;
                    dec_o.writes_rd = 1'b1;
                end
            end
            OP_LOAD: begin
                dec_o.imm      = imm_i;
                dec_o.alu_op   = ALU_ADD;                  // Effective address
                dec_o.op_a_sel = OPA_REG;
                if (funct3 != 3'b111) begin                // No ldu in RV64
                    dec_o.load      = 1'b1;
                    dec_o.writes_rd = 1'b1;
                end
            end
            OP_STORE: begin
                dec_o.imm      = imm_s;
                dec_o.alu_op   = ALU_ADD;
                dec_o.op_a_sel = OPA_REG;
                dec_o.store    = ~funct3[2];               // sb, sh, sw, sd
            end
            OP_BRANCH: begin
                dec_o.imm    = imm_b;
                dec_o.branch = (funct3 == 3'b000);         // beq only
            end
            OP_JAL: begin
                dec_o.imm       = imm_j;
                dec_o.jal       = 1'b1;
                dec_o.writes_rd = 1'b1;                    // Link written by control
            end
            OP_JALR: begin
                dec_o.imm       = imm_i;
                dec_o.jalr      = (funct3 == 3'b000);
                dec_o.writes_rd = (funct3 == 3'b000);
            end
            default: begin
                dec_o.mret = (instr_i == MRET);
            end
        endcase
    end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_idx_t  rs1_i,
    input  rv_pkg::reg_idx_t  rs2_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    input  rv_pkg::rf_write_t write_i
);
    import rv_pkg::*;

    word_t regs_q [`NUM_REGS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_i.en && write_i.addr != '0) begin  // x0 never written
            regs_q[write_i.addr] <= write_i.data;
        end
    end

    // x0 stays zero from reset on
    assign rs1_data_o = regs_q[rs1_i];
    assign rs2_data_o = regs_q[rs2_i];

endmodule

// ==== src/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::decoded_t dec_i,
    input  rv_pkg::word_t    pc_i,
    input  rv_pkg::word_t    rs1_data_i,
    input  rv_pkg::word_t    rs2_data_i,
    output rv_pkg::word_t    result_o,
    output logic             equal_o
);
    import rv_pkg::*;

    word_t op_a, op_b;

    always_comb begin
        case (dec_i.op_a_sel)
            OPA_REG: op_a = rs1_data_i;
            OPA_PC:  op_a = pc_i;                          // auipc
            default: op_a = '0;
        endcase
    end

    assign op_b = (dec_i.op_b_sel == OPB_IMM) ? dec_i.imm : rs2_data_i;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  result_o = op_a + op_b;              // Also load/store address
            ALU_SUB:  result_o = op_a - op_b;
            ALU_SLT:  result_o = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLL:  result_o = op_a << op_b[5:0];
            default:  result_o = op_b;
        endcase
    end

    // beq compares registers, not the selected operands
    assign equal_o = (rs1_data_i == rs2_data_i);

endmodule

// ==== src/rv_lsu.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_lsu (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::decoded_t dec_i,
    input  logic             ex_valid_i,
    input  rv_pkg::word_t    addr_i,
    input  rv_pkg::word_t    store_data_i,
    output rv_pkg::wb_req_t  bus_o,
    input  rv_pkg::wb_rsp_t  bus_i,
    output logic             busy_o,
    output rv_pkg::word_t    load_data_o,
    output logic             load_done_o
);
    import rv_pkg::*;

    logic               mem_op;
    logic               cyc_q, we_q;
    word_t              adr_q, dat_q;
    logic [`XLEN/8-1:0] sel_q, base_sel;
    word_t              lane_data;

    assign mem_op      = ex_valid_i & (dec_i.load | dec_i.store);
    assign busy_o      = mem_op;                           // Whole stay in execute
    assign load_done_o = cyc_q & bus_i.ack;                // Ends stores too

    always_comb begin
        case (dec_i.mem_size)
            MEM_BYTE: base_sel = 8'h01;
            MEM_HALF: base_sel = 8'h03;
            MEM_WORD: base_sel = 8'h0f;
            default:  base_sel = 8'hff;
        endcase
    end

    // Cycle control, idle again the cycle after ack
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (cyc_q) begin
            if (bus_i.ack) begin
                cyc_q <= 1'b0;
                we_q  <= 1'b0;
            end
        end else if (mem_op) begin
            cyc_q <= 1'b1;
            we_q  <= dec_i.store;
        end
    end

    // Address, lane-shifted data and selects, held until ack
    always_ff @(posedge clk) begin
        if (!cyc_q && mem_op) begin
            adr_q <= addr_i;
            dat_q <= store_data_i << {addr_i[2:0], 3'b000};
            sel_q <= base_sel << addr_i[2:0];
        end
    end

    assign bus_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q, sel: sel_q};

    // Load bytes come from the lane the request used
    assign lane_data = bus_i.dat >> {adr_q[2:0], 3'b000};

    always_comb begin
        case (dec_i.mem_size)
            MEM_BYTE: load_data_o = dec_i.load_unsigned ? word_t'(lane_data[7:0])
                                                        : word_t'($signed(lane_data[7:0]));
            MEM_HALF: load_data_o = dec_i.load_unsigned ? word_t'(lane_data[15:0])
                                                        : word_t'($signed(lane_data[15:0]));
            MEM_WORD: load_data_o = dec_i.load_unsigned ? word_t'(lane_data[31:0])
                                                        : word_t'($signed(lane_data[31:0]));
            default:  load_data_o = lane_data;             // ld, no extension
        endcase
    end

    // Idle for one cycle after every ack
    a_drop_after_ack: assert property (@(posedge clk) disable iff (!reset)
        bus_o.cyc && bus_i.ack |=> !bus_o.cyc && !bus_o.stb);

    // Request held while slave inserts wait states
    a_adr_hold: assert property (@(posedge clk) disable iff (!reset)
        bus_o.stb && !bus_i.ack |=> bus_o.stb && $stable(bus_o.adr));

endmodule

// ==== src/rv_trap.sv ====
`timescale 1ns/1ns

module rv_trap (
    input  logic             clk,
    input  logic             reset,
    input  logic             irq_i,
    input  rv_pkg::decoded_t dec_i,
    input  logic             ex_valid_i,
    input  rv_pkg::word_t    ex_pc_i,
    input  logic             mem_busy_i,
    output logic             take_o,
    output rv_pkg::word_t    mret_pc_o,
    output logic             irq_ack_o
);
    import rv_pkg::*;

    logic  mie_q, mpie_q;                                  // mstatus bits 3 and 7
    word_t mepc_q;

    // Only a real instruction with no bus access pending
    assign take_o    = irq_i & mie_q & ex_valid_i & ~mem_busy_i;
    assign mret_pc_o = mepc_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mie_q     <= 1'b1;
            mpie_q    <= 1'b0;
            irq_ack_o <= 1'b0;
        end else begin
            irq_ack_o <= take_o;                           // One cycle per acceptance
            if (take_o) begin
                mpie_q <= mie_q;
                mie_q  <= 1'b0;
            end else if (ex_valid_i && dec_i.mret) begin
                mie_q  <= mpie_q;
                mpie_q <= 1'b1;
            end
        end
    end

    // Interrupted instruction restarts here
    always_ff @(posedge clk) begin
        if (take_o) begin
            mepc_q <= ex_pc_i;
        end
    end

    // Bubble after the redirect and cleared MIE keep it single
    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        irq_ack_o |=> !irq_ack_o);

endmodule

// ==== src/rv_control.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_control (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     imem_addr_o,
    input  rv_pkg::instr_t    imem_data_i,
    input  rv_pkg::decoded_t  dec_i,
    input  rv_pkg::word_t     rs1_data_i,
    input  rv_pkg::word_t     rs2_data_i,
    input  rv_pkg::word_t     alu_result_i,
    input  logic              alu_equal_i,
    input  logic              mem_busy_i,
    input  rv_pkg::word_t     load_data_i,
    input  logic              load_done_i,
    input  logic              trap_take_i,
    input  rv_pkg::word_t     mret_pc_i,
    output rv_pkg::instr_t    instr_o,
    output rv_pkg::word_t     ex_pc_o,
    output logic              ex_valid_o,
    output rv_pkg::rf_write_t rf_write_o
);
    import rv_pkg::*;

    word_t  pc_q, ex_pc_q;
    instr_t instr_q;
    logic   ex_valid_q;
    logic   stall, taken, redirect;
    word_t  link_addr, branch_target, jalr_sum, next_pc;

    assign imem_addr_o = pc_q;
    assign instr_o     = instr_q;
    assign ex_pc_o     = ex_pc_q;
    assign ex_valid_o  = ex_valid_q;

    // Memory op holds fetch and PC until ack
    assign stall = mem_busy_i & ~load_done_i;

    assign taken    = dec_i.branch & alu_equal_i;
    assign redirect = trap_take_i
                    | (ex_valid_q & (taken | dec_i.jal | dec_i.jalr | dec_i.mret));

    assign link_addr     = ex_pc_q + 4;
    assign branch_target = ex_pc_q + dec_i.imm;            // beq and jal
    assign jalr_sum      = rs1_data_i + dec_i.imm;

    always_comb begin
        if (trap_take_i) begin
            next_pc = `TRAP_VECTOR;                        // Beats the squashed instr
        end else if (!redirect) begin
            next_pc = pc_q + 4;
        end else if (dec_i.mret) begin
            next_pc = mret_pc_i;
        end else if (dec_i.jalr) begin
            next_pc = {jalr_sum[$bits(word_t)-1:1], 1'b0};
        end else begin
            next_pc = branch_target;
        end
    end

    // PC and execute slot, a redirect leaves one bubble
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q       <= `RESET_PC;
            instr_q    <= `NOP_INSTR;
            ex_valid_q <= 1'b0;
        end else if (!stall) begin
            pc_q <= next_pc;
            if (redirect) begin
                instr_q    <= `NOP_INSTR;                  // Squash the fetched word
                ex_valid_q <= 1'b0;
            end else begin
                instr_q    <= imem_data_i;
                ex_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !redirect) begin
            ex_pc_q <= pc_q;
        end
    end

    // Writeback, a load only on its ack edge
    always_comb begin
        rf_write_o.addr = dec_i.rd;
        rf_write_o.en   = ex_valid_q & dec_i.writes_rd & ~trap_take_i
                        & (~dec_i.load | load_done_i);
        if (dec_i.load) begin
            rf_write_o.data = load_data_i;
        end else if (dec_i.jal || dec_i.jalr) begin
            rf_write_o.data = link_addr;
        end else begin
            rf_write_o.data = alu_result_i;
        end
    end

    // Jumps and traps never cut a bus access short
    a_redirect_no_bus: assert property (@(posedge clk) disable iff (!reset)
        redirect |-> !mem_busy_i);

    // Register file quiet while a bus access waits
    a_operands_held: assert property (@(posedge clk) disable iff (!reset)
        stall |=> $stable(rs1_data_i) && $stable(rs2_data_i));

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            irq_i,
    output rv_pkg::word_t   imem_addr_o,
    input  rv_pkg::instr_t  imem_data_i,
    output rv_pkg::wb_req_t data_bus_o,
    input  rv_pkg::wb_rsp_t data_bus_i,
    output logic            irq_ack_o
);
    import rv_pkg::*;

    instr_t    ex_instr;
    decoded_t  dec;
    word_t     ex_pc, rs1_data, rs2_data, alu_result, load_data, mret_pc;
    logic      ex_valid, alu_equal, mem_busy, load_done, trap_take;
    rf_write_t rf_write;

    rv_control i_control (
        .clk          (clk),
        .reset        (reset),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .dec_i        (dec),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .alu_result_i (alu_result),
        .alu_equal_i  (alu_equal),
        .mem_busy_i   (mem_busy),
        .load_data_i  (load_data),
        .load_done_i  (load_done),
        .trap_take_i  (trap_take),
        .mret_pc_i    (mret_pc),
        .instr_o      (ex_instr),
        .ex_pc_o      (ex_pc),
        .ex_valid_o   (ex_valid),
        .rf_write_o   (rf_write)
    );

    rv_decode i_decode (.instr_i(ex_instr), .dec_o(dec));

    rv_regfile i_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .write_i    (rf_write)
    );

    rv_alu i_alu (
        .dec_i      (dec),
        .pc_i       (ex_pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (alu_result),
        .equal_o    (alu_equal)
    );

    // Store data straight from rs2
    rv_lsu i_lsu (
        .clk          (clk),
        .reset        (reset),
        .dec_i        (dec),
        .ex_valid_i   (ex_valid),
        .addr_i       (alu_result),
        .store_data_i (rs2_data),
        .bus_o        (data_bus_o),
        .bus_i        (data_bus_i),
        .busy_o       (mem_busy),
        .load_data_o  (load_data),
        .load_done_o  (load_done)
    );

    rv_trap i_trap (
        .clk        (clk),
        .reset      (reset),
        .irq_i      (irq_i),
        .dec_i      (dec),
        .ex_valid_i (ex_valid),
        .ex_pc_i    (ex_pc),
        .mem_busy_i (mem_busy),
        .take_o     (trap_take),
        .mret_pc_o  (mret_pc),
        .irq_ack_o  (irq_ack_o)
    );

endmodule

// ==== tb/rv_wb_memory.sv ====
`timescale 1ns/1ns

module rv_wb_memory (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::word_t    imem_addr_i,
    output rv_pkg::instr_t   imem_data_o,
    input  rv_pkg::wb_req_t  bus_i,
    output rv_pkg::wb_rsp_t  bus_o,
    input  logic [2:0]       wait_i,       // Wait states for the next cycle
    output logic             wr_valid_o,   // One pulse per completed write
    output rv_pkg::word_t    wr_addr_o,
    output rv_pkg::word_t    wr_data_o     // Whole word after the write
);
    import rv_pkg::*;

    instr_t     rom [1024];
    word_t      ram [256];
    logic [7:0] idx;
    logic       active, ack_q;
    logic [2:0] count;
    word_t      rdat_q, merged;

    assign imem_data_o = rom[imem_addr_i[11:2]];       // Combinational fetch
    assign idx         = bus_i.adr[10:3];
    assign bus_o       = '{dat: rdat_q, ack: ack_q};

    // Old word with the selected lanes replaced
    always_comb begin
        merged = ram[idx];
        for (int i = 0; i < 8; i++) begin
            if (bus_i.sel[i]) begin
                merged[8*i +: 8] = bus_i.dat[8*i +: 8];
            end
        end
    end

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            active     <= 1'b0;
            ack_q      <= 1'b0;
            count      <= '0;
            wr_valid_o <= 1'b0;
        end else begin
            wr_valid_o <= 1'b0;
            if (ack_q) begin
                ack_q  <= 1'b0;                         // Master drops cyc here
                active <= 1'b0;
            end else if (active) begin
                if (count == 0) begin
                    ack_q  <= 1'b1;
                    rdat_q <= ram[idx];
                    if (bus_i.we) begin
                        ram[idx]   <= merged;
                        wr_valid_o <= 1'b1;
                        wr_addr_o  <= bus_i.adr;
                        wr_data_o  <= merged;
                    end
                end else begin
                    count <= count - 1'b1;              // Still waiting
                end
            end else if (bus_i.cyc && bus_i.stb) begin
                active <= 1'b1;
                count  <= wait_i;
            end
        end
    end

endmodule

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core_tb;
    import rv_pkg::*;

    localparam word_t MARKER_ADDR = 64'h7f8;           // Handler's store
    localparam int    K_ADD = 0, K_SUB = 1, K_SLT = 2, K_SLL = 3;

    logic       clk, reset, irq, irq_ack, wr_valid;
    word_t      imem_addr, wr_addr, wr_data;
    instr_t     imem_data;
    wb_req_t    bus_req;
    wb_rsp_t    bus_rsp;
    logic [2:0] wait_cycles, wait_mask;
    logic [31:0] lfsr_state;
    int         errors, acks, markers, pc, res_addr, prog_len;
    word_t      init_mem [256];
    logic [19:0] lui_imm;
    logic [11:0] addi_imm;
    logic [5:0] shamt;
    string      exp_name [$];
    word_t      exp_addr [$];
    word_t      exp_val [$];

    rv_core_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .irq_i       (irq),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .data_bus_o  (bus_req),
        .data_bus_i  (bus_rsp),
        .irq_ack_o   (irq_ack)
    );

    rv_wb_memory i_mem (
        .clk         (clk),
        .reset       (reset),
        .imem_addr_i (imem_addr),
        .imem_data_o (imem_data),
        .bus_i       (bus_req),
        .bus_o       (bus_rsp),
        .wait_i      (wait_cycles),
        .wr_valid_o  (wr_valid),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};  // beq
    endfunction

    function automatic instr_t enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Expected ALU results from the instruction rules
    function automatic word_t ref_alu(int kind, word_t a, word_t b);
        case (kind)
            K_ADD:   return a + b;
            K_SUB:   return a - b;
            K_SLT:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: return a << b[5:0];
        endcase
    endfunction

    // Load of funct3 f3 at byte offset off, extended
    function automatic word_t ref_load(word_t w, int off, int f3);
        word_t v;
        v = w >> (8 * off);
        case (f3)
            0: return {{56{v[7]}}, v[7:0]};
            1: return {{48{v[15]}}, v[15:0]};
            2: return {{32{v[31]}}, v[31:0]};
            4: return {56'b0, v[7:0]};
            5: return {48'b0, v[15:0]};
            6: return {32'b0, v[31:0]};
            default: return v;
        endcase
    endfunction

    // Word after a sub-word store, other bytes untouched
    function automatic word_t ref_store(word_t old, word_t data, int off, int size);
        for (int i = 0; i < (1 << size); i++) begin
            old[8*(off+i) +: 8] = data[8*i +: 8];
        end
        return old;
    endfunction

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic emit(input instr_t instr);
        i_mem.rom[pc / 4] = instr;
        pc += 4;
    endtask

    task automatic expect_write(input string name, input word_t addr, input word_t value);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_val.push_back(value);
    endtask

    // sd of rd into the next result slot
    task automatic push_result(input string name, input logic [4:0] rd, input word_t value);
        emit(enc_s(res_addr[11:0], rd, 5'd0, 3'd3));
        expect_write(name, res_addr, value);
        res_addr += 8;
    endtask

    task automatic build_program();
        word_t a, b, uimm, link;
        int    target;
        a        = init_mem[0];
        b        = init_mem[1];
        uimm     = {{32{lui_imm[19]}}, lui_imm, 12'b0};
        pc       = 0;
        res_addr = 'h400;
        exp_name.delete();
        exp_addr.delete();
        exp_val.delete();
        for (int i = 0; i < 1024; i++) begin
            i_mem.rom[i] = `NOP_INSTR;
        end
        emit(enc_i(12'h000, 5'd0, 3'd3, 5'd1, 7'b0000011));  // x1, x2 operands
        emit(enc_i(12'h008, 5'd0, 3'd3, 5'd2, 7'b0000011));
        emit({lui_imm, 5'd3, 7'b0110111});
        push_result("lui", 3, uimm);
        link = pc + uimm;                                     // auipc value
        emit({lui_imm, 5'd3, 7'b0010111});
        push_result("auipc", 3, link);
        emit(enc_i(addi_imm, 5'd1, 3'd0, 5'd3, 7'b0010011));
        push_result("addi", 3, ref_alu(K_ADD, a, {{52{addi_imm[11]}}, addi_imm}));
        emit(enc_i({6'b0, shamt}, 5'd1, 3'd1, 5'd3, 7'b0010011));
        push_result("slli", 3, ref_alu(K_SLL, a, word_t'(shamt)));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        push_result("add", 3, ref_alu(K_ADD, a, b));
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
        push_result("sub", 3, ref_alu(K_SUB, a, b));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3));
        push_result("slt pos-neg", 3, ref_alu(K_SLT, a, b));
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd3));
        push_result("slt neg-pos", 3, ref_alu(K_SLT, b, a));
        // Every load width at every aligned lane of word 2
        for (int f3 = 0; f3 < 7; f3++) begin
            for (int off = 0; off < 8; off += (1 << (f3 % 4))) begin
                emit(enc_i(12'h010 + off, 5'd0, f3, 5'd3, 7'b0000011));
                push_result($sformatf("load f3=%0d off=%0d", f3, off), 3,
                            ref_load(init_mem[2], off, f3));
            end
        end
        emit(enc_s(12'h01d, 5'd2, 5'd0, 3'd0));              // sb lane 5
        expect_write("sb", 'h1d, ref_store(init_mem[3], b, 5, 0));
        emit(enc_s(12'h022, 5'd2, 5'd0, 3'd1));              // sh lane 2
        expect_write("sh", 'h22, ref_store(init_mem[4], b, 2, 1));
        emit(enc_s(12'h02c, 5'd2, 5'd0, 3'd2));              // sw lane 4
        expect_write("sw", 'h2c, ref_store(init_mem[5], b, 4, 2));
        emit(enc_b(13'd8, 5'd1, 5'd1));                      // Taken, skips next
        emit(enc_s(12'h3f0, 5'd1, 5'd0, 3'd3));
        emit(enc_b(13'd8, 5'd2, 5'd1));                      // Not taken
        push_result("beq not taken", 1, a);
        link = pc + 4;
        emit(enc_j(21'd8, 5'd4));
        emit(enc_s(12'h3f0, 5'd1, 5'd0, 3'd3));              // Skipped
        push_result("jal link", 4, link);
        target = pc + 12;
        emit(enc_i(target[11:0], 5'd0, 3'd0, 5'd6, 7'b0010011));
        link = pc + 4;
        emit(enc_i(12'h000, 5'd6, 3'd0, 5'd5, 7'b1100111));  // jalr x5, 0(x6)
        emit(enc_s(12'h3f0, 5'd1, 5'd0, 3'd3));              // Skipped
        push_result("jalr link", 5, link);
        emit(enc_j(21'd0, 5'd0));                            // Park here
        prog_len = pc / 4;
        if (pc > int'(`TRAP_VECTOR)) begin
            $display("Program overlaps the trap handler");
            errors++;
        end
        pc = int'(`TRAP_VECTOR);                              // Handler
        emit(enc_i(12'h001, 5'd31, 3'd0, 5'd31, 7'b0010011));
        emit(enc_s(MARKER_ADDR[11:0], 5'd31, 5'd0, 3'd3));
        emit(32'h3020_0073);                                 // mret
    endtask

    task automatic run_program(input logic [2:0] mask, input logic with_irq);
        @(posedge clk);
        #2;
        reset     = 1'b0;
        irq       = 1'b0;
        wait_mask = mask;
        build_program();
        for (int i = 0; i < 256; i++) begin
            i_mem.ram[i] = init_mem[i];
        end
        acks    = 0;
        markers = 0;
        repeat (3) @(posedge clk);
        #2 reset = 1'b1;
        if (with_irq) begin
            repeat (30) @(posedge clk);
            #2 irq = 1'b1;
            wait (markers == 1);                             // Held through the handler
            @(posedge clk);
            #2 irq = 1'b0;
        end
        wait (exp_val.size() == 0);
        repeat (20) @(posedge clk);                          // Catch stray stores
        check("irq acks", word_t'(with_irq), word_t'(acks));
        check("irq markers", word_t'(with_irq), word_t'(markers));
    endtask

    // New wait count each cycle
    always @(posedge clk) begin
        #1 wait_cycles = 3'(take_bits(3)) & wait_mask;
    end

    // Compare recorded writes with the expected queue
    always @(negedge clk) begin
        if (wr_valid) begin
            if (wr_addr == MARKER_ADDR) begin
                markers++;
                check("irq marker", 64'd1, wr_data);
            end else if (exp_val.size() == 0) begin
                $display("Unexpected store of %h to address %h", wr_data, wr_addr);
                errors++;
            end else begin
                check({exp_name[0], " address"}, exp_addr.pop_front(), wr_addr);
                check(exp_name.pop_front(), exp_val.pop_front(), wr_data);
            end
        end
        if (irq_ack) begin
            acks++;
        end
    end

    // Both runs, worst case wait on every instruction
    initial begin
        wait (prog_len > 0);
        #(prog_len * 2 * 16 * 20 + 20000);
        $display("Timeout, the program did not finish its stores");
        $display("Something failed");
        $finish;
    end

    initial begin
        reset       = 1'b0;
        irq         = 1'b0;
        wait_cycles = '0;
        wait_mask   = '0;
        errors      = 0;
        prog_len    = 0;
        lfsr_state  = 32'h30c7;
        for (int i = 0; i < 256; i++) begin
            init_mem[i] = take_bits(64);
        end
        init_mem[0][63] = 1'b0;                              // Mixed signs for slt
        init_mem[1][63] = 1'b1;
        lui_imm  = 20'(take_bits(20));
        addi_imm = 12'(take_bits(12));
        shamt    = 6'(take_bits(6));
        run_program(3'b000, 1'b0);
        run_program(3'b111, 1'b1);                           // Same stores with waits
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+src
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_trap.sv
src/rv_control.sv
src/rv_core_top.sv
tb/rv_wb_memory.sv
tb/rv_core_tb.sv
